// File: source/aluPkg.sv
// ALU definitions shared by the datapath and the ALU
// word width and word type, operation codes and the result flag struct

package aluPkg;

  // datapath width
  localparam int wordWidth = 32;

  // shift amount comes from the low bits of operand b
  localparam int shamtWidth = 5;

  typedef logic [wordWidth-1:0] word;

  // 4-bit operation code
  typedef logic [3:0] aluOp;

  // shifts
  localparam aluOp opSll = 4'd0;
  localparam aluOp opSrl = 4'd1;

  // arithmetic
  localparam aluOp opAdd = 4'd2;
  localparam aluOp opSub = 4'd3;

  // bitwise logic
  localparam aluOp opAnd = 4'd4;
  localparam aluOp opOr = 4'd5;
  localparam aluOp opXor = 4'd6;
  localparam aluOp opNor = 4'd7;

  // comparisons, result is 1 or 0
  // codes 8, 9 and 12 to 15 are left undefined
  localparam aluOp opSlt = 4'd10;
  localparam aluOp opSltu = 4'd11;

  // result flags, reported alongside every result
  typedef struct packed {
    // copy of the result's top bit
    logic neg;
    // signed overflow, add and subtract only
    logic ovf;
    // result is all zeros
    logic zero;
  } aluFlags;

endpackage

// File: source/execPkg.sv
// execute unit definitions
// register file geometry, immediate width,
// incoming instruction fields and the two pipeline payloads

package execPkg;

  // register file geometry
  localparam int regCount = 32;
  localparam int regAddrWidth = 5;

  // immediate field as it arrives, sign-extended on issue
  localparam int immWidth = 16;

  typedef logic [regAddrWidth-1:0] regAddr;

  // pre-decoded instruction, 36 bits
  typedef struct packed {
    aluPkg::aluOp op;
    regAddr rs;
    regAddr rt;
    regAddr rd;
    logic useImm;
    logic [immWidth-1:0] imm;
  } instr;

  // stage 1 payload, operands already resolved, 73 bits
  typedef struct packed {
    aluPkg::aluOp op;
    regAddr rd;
    aluPkg::word a;
    aluPkg::word b;
  } operandStage;

  // stage 2 payload, waiting for writeback, 40 bits
  typedef struct packed {
    regAddr rd;
    aluPkg::word result;
    aluPkg::aluFlags flags;
  } resultStage;

endpackage

// File: source/aluIf.sv
// execute datapath to ALU connection
// operands and op code in, result and three flags out

interface aluIf;
  import aluPkg::*;

  word portA;
  word portB;
  aluOp op;
  word portOut;
  logic flagNeg;
  logic flagOvf;
  logic flagZero;

  // ALU side, purely combinational
  modport alu (
    input portA, portB, op,
    output portOut, flagNeg, flagOvf, flagZero
  );

  // datapath side
  modport exec (
    output portA, portB, op,
    input portOut, flagNeg, flagOvf, flagZero
  );

endinterface

// File: source/registerFileIf.sv
// register file connection
// one write port and two combinational read ports

interface registerFileIf;
  import aluPkg::*;
  import execPkg::*;

  logic wen;
  regAddr wsel;
  word wdat;
  regAddr rsel1;
  regAddr rsel2;
  word rdat1;
  word rdat2;

  modport rf (
    input wen, wsel, wdat, rsel1, rsel2,
    output rdat1, rdat2
  );

  modport exec (
    output wen, wsel, wdat, rsel1, rsel2,
    input rdat1, rdat2
  );

endinterface

// File: source/alu.sv
// combinational ALU
// shifts, add/sub, bitwise logic, signed and unsigned set-less-than,
// negative, overflow and zero flags

module alu (
  aluIf.alu aluBus
);
  import aluPkg::*;

  word a;
  word b;
  word result;
  logic [shamtWidth-1:0] shamt;
  logic ovf;
  logic signedLess;
  logic unsignedLess;

  assign a = aluBus.portA;
  assign b = aluBus.portB;

  // only the low five bits of b count as a shift amount
  assign shamt = b[shamtWidth-1:0];

  assign signedLess = $signed(a) < $signed(b);
  assign unsignedLess = a < b;

  always_comb begin
    result = '0;
    ovf = 1'b0;
    case (aluBus.op)
      opSll: begin
        result = a << shamt;
      end
      opSrl: begin
        result = a >> shamt;
      end
      opAdd: begin
        result = a + b;
        // same-sign operands giving a different-sign sum
        ovf = (a[wordWidth-1] == b[wordWidth-1]) &&
              (result[wordWidth-1] != a[wordWidth-1]);
      end
      opSub: begin
        result = a - b;
        // opposite-sign operands, sign of a lost
        ovf = (a[wordWidth-1] != b[wordWidth-1]) &&
              (result[wordWidth-1] != a[wordWidth-1]);
      end
      opAnd: begin
        result = a & b;
      end
      opOr: begin
        result = a | b;
      end
      opXor: begin
        result = a ^ b;
      end
      opNor: begin
        result = ~(a | b);
      end
      opSlt: begin
        result = {{(wordWidth-1){1'b0}}, signedLess};
      end
      opSltu: begin
        result = {{(wordWidth-1){1'b0}}, unsignedLess};
      end
      default: begin
        // undefined codes give zero
        result = '0;
      end
    endcase
  end

  assign aluBus.portOut = result;
  assign aluBus.flagNeg = result[wordWidth-1];
  assign aluBus.flagOvf = ovf;
  assign aluBus.flagZero = (result == '0);

endmodule

// File: source/registerFile.sv
// 32 x 32-bit register file
// register zero hard-wired to zero, write on the rising edge,
// two combinational read ports

module registerFile (
  input logic CLK,
  input logic rstN,
  registerFileIf.rf rfBus
);
  import aluPkg::*;
  import execPkg::*;

  // no storage behind register zero
  word regs [1:regCount-1];

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (rfBus.wen && (rfBus.wsel != '0)) begin
      regs[rfBus.wsel] <= rfBus.wdat;
    end
  end

  // reads see stored contents only, the datapath bypasses newer values
  assign rfBus.rdat1 = (rfBus.rsel1 == '0) ? '0 : regs[rfBus.rsel1];
  assign rfBus.rdat2 = (rfBus.rsel2 == '0) ? '0 : regs[rfBus.rsel2];

endmodule

// File: source/pipeStage.sv
// valid-qualified pipeline register
// payload type is a parameter, one cycle of latency

module pipeStage #(
  parameter type payloadType = logic
) (
  input logic CLK,
  input logic rstN,
  input logic inValid,
  input payloadType inData,
  output logic outValid,
  output payloadType outData
);

  // control bit
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  // payload held while the slot is empty
  always_ff @(posedge CLK) begin
    if (inValid) begin
      outData <= inData;
    end
  end

endmodule

// File: source/execUnit.sv
// two-stage integer execute unit
// operand read with bypassing, immediate select,
// operand and result pipeline stages, writeback and output ports

module execUnit (
  input logic CLK,
  input logic rstN,
  input logic inValid,
  input aluPkg::aluOp inOp,
  input execPkg::regAddr inRs,
  input execPkg::regAddr inRt,
  input execPkg::regAddr inRd,
  input logic inUseImm,
  input logic [execPkg::immWidth-1:0] inImm,
  output logic outValid,
  output execPkg::regAddr outRd,
  output logic [aluPkg::wordWidth-1:0] outResult,
  output logic outNeg,
  output logic outOvf,
  output logic outZero
);
  import aluPkg::*;
  import execPkg::*;

  instr issue;
  word immExt;
  word opA;
  word rtData;
  word opB;
  execPkg::operandStage issueData;
  execPkg::operandStage s1Data;
  execPkg::resultStage s2In;
  execPkg::resultStage s2Data;
  logic s1Valid;
  logic s2Valid;

  aluIf aluBus ();
  registerFileIf rfBus ();

  // newest in-flight value wins: stage 1 result, then stage 2, then the file
  function automatic word pickOperand(
    input regAddr sel,
    input word fileData,
    input logic hit1Valid,
    input regAddr hit1Rd,
    input word hit1Data,
    input logic hit2Valid,
    input regAddr hit2Rd,
    input word hit2Data
  );
    word value;
    if (sel == '0) begin
      value = '0;
    end else if (hit1Valid && (hit1Rd == sel)) begin
      value = hit1Data;
    end else if (hit2Valid && (hit2Rd == sel)) begin
      value = hit2Data;
    end else begin
      value = fileData;
    end
    return value;
  endfunction

  assign issue = '{op: inOp, rs: inRs, rt: inRt, rd: inRd,
                   useImm: inUseImm, imm: inImm};

  // issue cycle, read both sources
  assign rfBus.rsel1 = issue.rs;
  assign rfBus.rsel2 = issue.rt;

  assign immExt = {{(wordWidth-immWidth){issue.imm[immWidth-1]}}, issue.imm};

  assign opA = pickOperand(issue.rs, rfBus.rdat1,
                           s1Valid, s1Data.rd, aluBus.portOut,
                           s2Valid, s2Data.rd, s2Data.result);
  assign rtData = pickOperand(issue.rt, rfBus.rdat2,
                              s1Valid, s1Data.rd, aluBus.portOut,
                              s2Valid, s2Data.rd, s2Data.result);

  assign opB = issue.useImm ? immExt : rtData;

  assign issueData = '{op: issue.op, rd: issue.rd, a: opA, b: opB};

  pipeStage #(.payloadType(execPkg::operandStage)) operandStage (
    .CLK(CLK),
    .rstN(rstN),
    .inValid(inValid),
    .inData(issueData),
    .outValid(s1Valid),
    .outData(s1Data)
  );

  // stage 1 drives the ALU
  assign aluBus.portA = s1Data.a;
  assign aluBus.portB = s1Data.b;
  assign aluBus.op = s1Data.op;

  alu aluInst (
    .aluBus(aluBus.alu)
  );

  assign s2In = '{rd: s1Data.rd,
                  result: aluBus.portOut,
                  flags: '{neg: aluBus.flagNeg, ovf: aluBus.flagOvf,
                           zero: aluBus.flagZero}};

  pipeStage #(.payloadType(execPkg::resultStage)) resultStage (
    .CLK(CLK),
    .rstN(rstN),
    .inValid(s1Valid),
    .inData(s2In),
    .outValid(s2Valid),
    .outData(s2Data)
  );

  // writeback from stage 2, the file drops writes to register zero
  assign rfBus.wen = s2Valid;
  assign rfBus.wsel = s2Data.rd;
  assign rfBus.wdat = s2Data.result;

  registerFile regFile (
    .CLK(CLK),
    .rstN(rstN),
    .rfBus(rfBus.rf)
  );

  assign outValid = s2Valid;
  assign outRd = s2Data.rd;
  assign outResult = s2Data.result;
  assign outNeg = s2Data.flags.neg;
  assign outOvf = s2Data.flags.ovf;
  assign outZero = s2Data.flags.zero;

endmodule

// File: verification/tbClock.sv
// testbench clock and reset
// 20 ns period, reset held low for five rising edges

module tbClock (
  output logic CLK,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  initial begin
    rstN = 1'b0;
    repeat (5) @(posedge CLK);
    rstN <= 1'b1;
  end

endmodule

// File: verification/execUnit_assertions.sv
// concurrent checks bound to the execute unit
// two-cycle latency, quiet outputs in reset, zero flag consistency

module execUnitAssertions (
  input logic CLK,
  input logic rstN,
  input logic inValid,
  input logic outValid,
  input logic [aluPkg::wordWidth-1:0] outResult,
  input logic outZero
);
  timeunit 1ns;
  timeprecision 1ps;

  // failures so far, added to the testbench total
  int failCount = 0;

  // result leaves two edges after the instruction is accepted
  latencyTwo: assert property (@(posedge CLK) disable iff (!rstN)
    outValid == $past(inValid, 2))
  else begin
    $error("outValid does not follow inValid by two cycles");
    failCount++;
  end

  resetQuiet: assert property (@(posedge CLK) !rstN |-> !outValid)
  else begin
    $error("outValid is high during reset");
    failCount++;
  end

  zeroFlag: assert property (@(posedge CLK) disable iff (!rstN)
    outValid |-> (outZero == (outResult == '0)))
  else begin
    $error("outZero disagrees with outResult");
    failCount++;
  end

endmodule

bind execUnit execUnitAssertions checks (
  .CLK(CLK),
  .rstN(rstN),
  .inValid(inValid),
  .outValid(outValid),
  .outResult(outResult),
  .outZero(outZero)
);

// File: verification/execUnitTb.sv
// testbench for the execute unit
// directed tests, reference model with shadow registers,
// LFSR stimulus, result monitor and cycle timeout

module execUnitTb;
  timeunit 1ns;
  timeprecision 1ps;
  import aluPkg::*;
  import execPkg::*;

  // instructions issued by the tests, sets the timeout
  localparam int plannedInstructions = 32 + 16 + 13 + 18 + 3 + 60;
  localparam int cycleLimit = 2 * plannedInstructions + 100;

  logic CLK;
  logic rstN;
  logic inValid;
  aluOp inOp;
  regAddr inRs;
  regAddr inRt;
  regAddr inRd;
  logic inUseImm;
  logic [immWidth-1:0] inImm;
  logic outValid;
  regAddr outRd;
  word outResult;
  logic outNeg;
  logic outOvf;
  logic outZero;

  resultStage expectedQ [$];
  int driveEdgeQ [$];
  word shadow [regCount];
  logic [31:0] lfsrState;
  int errors = 0;
  int cycles = 0;

  tbClock clockGen (.CLK(CLK), .rstN(rstN));

  execUnit uut (.*);

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] nextBits(input int count);
    logic [31:0] bits;
    logic feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      bits = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  function automatic word readShadow(input regAddr sel);
    return (sel == 5'd0) ? 32'd0 : shadow[sel];
  endfunction

  // reference ALU, overflow from the exact 64-bit sum
  function automatic resultStage modelExec(input aluOp op, input regAddr rd,
                                           input word a, input word b);
    resultStage r;
    longint wide;
    r.rd = rd;
    r.result = '0;
    r.flags.ovf = 1'b0;
    case (op)
      opSll: r.result = a << b[4:0];
      opSrl: r.result = a >> b[4:0];
      opAdd: begin
        r.result = a + b;
        wide = longint'($signed(a)) + longint'($signed(b));
        r.flags.ovf = wide != longint'($signed(r.result));
      end
      opSub: begin
        r.result = a - b;
        wide = longint'($signed(a)) - longint'($signed(b));
        r.flags.ovf = wide != longint'($signed(r.result));
      end
      opAnd: r.result = a & b;
      opOr: r.result = a | b;
      opXor: r.result = a ^ b;
      opNor: r.result = ~(a | b);
      opSlt: r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      opSltu: r.result = (a < b) ? 32'd1 : 32'd0;
      default: r.result = '0;
    endcase
    r.flags.neg = r.result[31];
    r.flags.zero = r.result == 32'd0;
    return r;
  endfunction

  task automatic issueInstr(input aluOp op, input regAddr rs, input regAddr rt,
                            input regAddr rd, input logic useImm, input logic [15:0] imm);
    word b;
    resultStage expected;
    @(posedge CLK);
    inValid <= 1'b1;
    inOp <= op;
    inRs <= rs;
    inRt <= rt;
    inRd <= rd;
    inUseImm <= useImm;
    inImm <= imm;
    b = useImm ? {{16{imm[15]}}, imm} : readShadow(rt);
    expected = modelExec(op, rd, readShadow(rs), b);
    expectedQ.push_back(expected);
    // number of the edge that drives this instruction
    driveEdgeQ.push_back(cycles + 1);
    if (rd != 5'd0) shadow[rd] = expected.result;
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge CLK);
      inValid <= 1'b0;
    end
  endtask

  task automatic checkResetState();
    wait (rstN === 1'b1);
    repeat (3) begin
      @(negedge CLK);
      checkValue("outValid", 32'd0, 32'(outValid));
    end
    for (int i = 0; i < regCount; i++) begin
      issueInstr(opOr, 5'(i), 5'd0, 5'd0, 1'b1, 16'h0000);
    end
    idleCycles(4);
  endtask

  task automatic applyEveryOp();
    issueInstr(opOr, 5'd0, 5'd0, 5'd1, 1'b1, 16'h1234);
    issueInstr(opOr, 5'd0, 5'd0, 5'd2, 1'b1, 16'hfffb);
    issueInstr(opSll, 5'd1, 5'd0, 5'd3, 1'b1, 16'd1);
    issueInstr(opSll, 5'd1, 5'd0, 5'd4, 1'b1, 16'd10);
    // 35 and 33 shift by their low five bits
    issueInstr(opSrl, 5'd2, 5'd0, 5'd5, 1'b1, 16'd35);
    issueInstr(opSll, 5'd1, 5'd0, 5'd6, 1'b1, 16'd33);
    issueInstr(opAdd, 5'd1, 5'd2, 5'd7, 1'b0, 16'd0);
    issueInstr(opSub, 5'd1, 5'd2, 5'd8, 1'b0, 16'd0);
    issueInstr(opAnd, 5'd1, 5'd2, 5'd9, 1'b0, 16'd0);
    issueInstr(opOr, 5'd1, 5'd2, 5'd10, 1'b0, 16'd0);
    issueInstr(opXor, 5'd1, 5'd2, 5'd11, 1'b0, 16'd0);
    issueInstr(opNor, 5'd1, 5'd2, 5'd12, 1'b0, 16'd0);
    // -5 against 0x1234, signed and unsigned order differ
    issueInstr(opSlt, 5'd2, 5'd1, 5'd13, 1'b0, 16'd0);
    issueInstr(opSltu, 5'd2, 5'd1, 5'd14, 1'b0, 16'd0);
    issueInstr(opSlt, 5'd1, 5'd2, 5'd15, 1'b0, 16'd0);
    issueInstr(opSltu, 5'd1, 5'd2, 5'd16, 1'b0, 16'd0);
    idleCycles(4);
  endtask

  task automatic probeFlags();
    issueInstr(opOr, 5'd0, 5'd0, 5'd17, 1'b1, 16'hffff);
    issueInstr(opSrl, 5'd17, 5'd0, 5'd18, 1'b1, 16'd1);
    issueInstr(opSll, 5'd17, 5'd0, 5'd19, 1'b1, 16'd31);
    issueInstr(opAdd, 5'd18, 5'd0, 5'd20, 1'b1, 16'd1);
    issueInstr(opSub, 5'd19, 5'd0, 5'd21, 1'b1, 16'd1);
    issueInstr(opAdd, 5'd2, 5'd0, 5'd22, 1'b1, 16'd5);
    issueInstr(opSub, 5'd0, 5'd0, 5'd23, 1'b1, 16'd7);
    issueInstr(opXor, 5'd18, 5'd19, 5'd24, 1'b0, 16'd0);
    issueInstr(opOr, 5'd18, 5'd19, 5'd25, 1'b0, 16'd0);
    // undefined codes
    issueInstr(4'd8, 5'd1, 5'd2, 5'd30, 1'b0, 16'd0);
    issueInstr(4'd9, 5'd1, 5'd2, 5'd30, 1'b0, 16'd0);
    issueInstr(4'd12, 5'd1, 5'd2, 5'd30, 1'b0, 16'd0);
    issueInstr(4'd15, 5'd1, 5'd2, 5'd30, 1'b0, 16'd0);
    idleCycles(4);
  endtask

  // gap 0 hits stage 1, gap 1 stage 2, gap 2 the register file
  task automatic runDependentChain(input int gap);
    issueInstr(opOr, 5'd0, 5'd0, 5'd26, 1'b1, 16'd1);
    repeat (4) begin
      idleCycles(gap);
      issueInstr(opAdd, 5'd26, 5'd0, 5'd26, 1'b1, 16'd3);
    end
    idleCycles(gap);
    issueInstr(opAdd, 5'd26, 5'd26, 5'd27, 1'b0, 16'd0);
    idleCycles(4);
  endtask

  task automatic writeRegisterZero();
    issueInstr(opAdd, 5'd1, 5'd0, 5'd0, 1'b1, 16'd5);
    issueInstr(opOr, 5'd0, 5'd0, 5'd28, 1'b1, 16'd0);
    idleCycles(3);
    issueInstr(opAdd, 5'd0, 5'd0, 5'd29, 1'b0, 16'd0);
    idleCycles(4);
  endtask

  task automatic runRandomBurst();
    aluOp op;
    regAddr rs;
    regAddr rt;
    regAddr rd;
    logic useImm;
    logic [15:0] imm;
    for (int i = 0; i < 60; i++) begin
      op = 4'(nextBits(4));
      rs = 5'(nextBits(5));
      rt = 5'(nextBits(5));
      rd = 5'(nextBits(5));
      useImm = 1'(nextBits(1));
      imm = 16'(nextBits(16));
      issueInstr(op, rs, rt, rd, useImm, imm);
    end
    idleCycles(4);
  endtask

  // result monitor, outputs settle well before the falling edge
  initial begin
    resultStage head;
    int driveEdge;
    forever begin
      @(negedge CLK);
      if (rstN && outValid) begin
        if (expectedQ.size() == 0) begin
          $display("ERROR at %0t ns: outValid is high with no result expected", $time);
          errors++;
        end else begin
          head = expectedQ.pop_front();
          driveEdge = driveEdgeQ.pop_front();
          checkValue("outRd", 32'(head.rd), 32'(outRd));
          checkValue("outResult", head.result, outResult);
          checkValue("outNeg", 32'(head.flags.neg), 32'(outNeg));
          checkValue("outOvf", 32'(head.flags.ovf), 32'(outOvf));
          checkValue("outZero", 32'(head.flags.zero), 32'(outZero));
          checkValue("outValid cycle", 32'(driveEdge + 2), 32'(cycles));
        end
      end
    end
  end

  initial begin
    while (cycles < cycleLimit) begin
      @(posedge CLK);
      cycles <= cycles + 1;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    inValid = 1'b0;
    inOp = '0;
    inRs = '0;
    inRt = '0;
    inRd = '0;
    inUseImm = 1'b0;
    inImm = '0;
    lfsrState = 32'h2661_2524;
    for (int i = 0; i < regCount; i++) begin
      shadow[i] = '0;
    end
    checkResetState();
    applyEveryOp();
    probeFlags();
    runDependentChain(0);
    runDependentChain(1);
    runDependentChain(2);
    writeRegisterZero();
    runRandomBurst();
    if (expectedQ.size() != 0) begin
      $display("ERROR: %0d expected results never appeared", expectedQ.size());
      errors++;
    end
    $display("done: %0d check errors, %0d assertion failures",
             errors, uut.checks.failCount);
    if (errors + uut.checks.failCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
source/aluPkg.sv
source/execPkg.sv
source/aluIf.sv
source/registerFileIf.sv
source/alu.sv
source/registerFile.sv
source/pipeStage.sv
source/execUnit.sv
verification/tbClock.sv
verification/execUnit_assertions.sv
verification/execUnitTb.sv

// File: Makefile
# Verilator build and run for the execute unit testbench

TOOL = verilator
FLAGS = --binary --timing --assert
TOP = execUnitTb
FILELIST = src.f
SIMFLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
